//--- common/fetch_pkg.sv
// ----------------------------------------------------------------------
// shared types for the instruction-fetch subsystem
// instruction words and addresses are 32 bits, addresses are byte based
// the opcode sits in the top six bits of every instruction word
// a jump carries a signed word offset in its low bits, relative to its pc
// ----------------------------------------------------------------------
package fetch_pkg;

   // byte address, also used for every program counter
   typedef logic [31:0] addr_t;
   // one instruction word
   typedef logic [31:0] insn_t;
   // major opcode field
   typedef logic [5:0]  opcode_t;

   // relative jump, always followed by one delay slot
   localparam opcode_t OPC_JUMP = 6'h00;
   localparam opcode_t OPC_NOP  = 6'h05;

   // width of the jump offset field below the opcode
   localparam int JUMP_OFF_W = 26;

   // word handed to decode in place of a faulted fetch
   localparam insn_t NOP_INSN = {OPC_NOP, {JUMP_OFF_W{1'b0}}};

   // sequential pc increment, one word
   localparam addr_t PC_STEP = 32'd4;

   // fetch stage toward decode, 66 bits
   typedef struct packed {
      addr_t pc;
      insn_t insn;
      logic  ibus_err;
      // set on the delay-slot word of a taken jump
      logic  branch_taken;
   } decode_bus_t;

   // instruction bus request, fetch to memory
   typedef struct packed {
      logic  req;
      addr_t addr;
   } ibus_req_t;

   // instruction bus response, memory to fetch
   // ack and err are one-cycle strobes, never both
   typedef struct packed {
      logic  ack;
      logic  err;
      insn_t dat;
   } ibus_rsp_t;

endpackage

//--- fetch/fetch_unit.sv
// ----------------------------------------------------------------------
// address and fetch stage, one request outstanding at a time
// the bus must answer each sampled request with ack or err, and sample
// again only on the cycle after its response (imem_bus behaviour)
// branch_occur_i must already be high when the delay slot is captured
// an err response halts fetching until du_restart_i
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module fetch_unit import fetch_pkg::*; #(
   parameter addr_t RESET_PC = 32'h0000_0100
) (
   input  logic        clk,
   input  logic        rst,

   // pipeline control
   input  logic        padv_i,
   input  logic        pipeline_flush_i,

   // debug restart
   input  logic        du_restart_i,
   input  addr_t       du_restart_pc_i,

   // branch request from predecode
   input  logic        branch_occur_i,
   input  addr_t       branch_dest_i,

   // instruction bus
   input  ibus_rsp_t   ibus_rsp_i,
   output ibus_req_t   ibus_req_o,

   // toward decode
   output decode_bus_t decode_o,
   output logic        fetch_valid_o
);

   // pc of the word in flight, or of the next request
   addr_t pc_fetch;
   // combinational address-stage pc
   addr_t pc_addr;
   // address stage may request, low after a bus error
   logic  padv_addr;

   // local copy of the memory's outstanding-request state
   logic  bus_busy;
   // outstanding response belongs to an address before a restart
   logic  bus_stale;
   logic  bus_done;
   logic  capture;
   logic  branch_pending;

   // registered decode fields
   addr_t dec_pc;
   insn_t dec_insn;
   logic  dec_err;
   logic  dec_taken;

   assign bus_done = ibus_rsp_i.ack | ibus_rsp_i.err;

   // take the response when decode slot is empty or being consumed
   // responses that meet a full, stalled slot are dropped and refetched
   assign capture = bus_done & !bus_stale & !du_restart_i &
                    (padv_i | !fetch_valid_o);

   // jump seen but delay slot not yet delivered
   assign branch_pending = branch_occur_i & !dec_taken;

   // next address
   // branch dest only replaces the step on the delay-slot capture,
   // so the delay slot itself is never skipped
   always_comb begin
      if (du_restart_i)
         pc_addr = du_restart_pc_i;
      else if (capture & branch_pending)
         pc_addr = branch_dest_i;
      else if (capture & ibus_rsp_i.ack)
         pc_addr = pc_fetch + PC_STEP;
      else
         pc_addr = pc_fetch;
   end

   // outside capture cycles pc_addr equals pc_fetch, which is what
   // the memory samples when it goes idle
   assign ibus_req_o.req  = padv_addr | du_restart_i;
   assign ibus_req_o.addr = pc_addr;

   always_ff @(posedge clk) begin
      if (rst)
         pc_fetch <= RESET_PC;
      else if (du_restart_i | capture)
         pc_fetch <= pc_addr;
   end

   // halt on a captured error, resume on restart
   always_ff @(posedge clk) begin
      if (rst)
         padv_addr <= 1'b1;
      else if (du_restart_i)
         padv_addr <= 1'b1;
      else if (capture & ibus_rsp_i.err)
         padv_addr <= 1'b0;
   end

   // track the request in flight so a restart can drop its answer
   always_ff @(posedge clk) begin
      if (rst) begin
         bus_busy  <= 1'b0;
         bus_stale <= 1'b0;
      end else if (bus_done) begin
         bus_busy  <= 1'b0;
         bus_stale <= 1'b0;
      end else if (!bus_busy) begin
         bus_busy  <= ibus_req_o.req;
      end else if (du_restart_i) begin
         bus_stale <= 1'b1;
      end
   end

   // valid holds through a stall, drops after consumption
   always_ff @(posedge clk) begin
      if (rst)
         fetch_valid_o <= 1'b0;
      else if (pipeline_flush_i | du_restart_i)
         fetch_valid_o <= 1'b0;
      else if (capture)
         fetch_valid_o <= 1'b1;
      else if (padv_i)
         fetch_valid_o <= 1'b0;
   end

   // error and taken flags
   // taken marks the word captured while the branch is pending
   always_ff @(posedge clk) begin
      if (rst) begin
         dec_err   <= 1'b0;
         dec_taken <= 1'b0;
      end else if (du_restart_i) begin
         dec_err   <= 1'b0;
         dec_taken <= 1'b0;
      end else if (capture) begin
         dec_err   <= ibus_rsp_i.err;
         dec_taken <= branch_pending;
      end
   end

   // pc and instruction payload
   always_ff @(posedge clk) begin
      if (capture) begin
         dec_pc   <= pc_fetch;
         dec_insn <= ibus_rsp_i.ack ? ibus_rsp_i.dat : NOP_INSN;
      end
   end

   assign decode_o.pc           = dec_pc;
   assign decode_o.insn         = dec_insn;
   assign decode_o.ibus_err     = dec_err;
   assign decode_o.branch_taken = dec_taken;

endmodule

//--- src/imem_bus.sv
// ----------------------------------------------------------------------
// instruction memory, 2**IMEM_AW words, no reset on contents
// answers each request WAIT_CYCLES (>= 1) cycles after sampling it
// err instead of ack for word addresses at or above 2**IMEM_AW
// IMEM_AW up to 29; load writes outside the array are ignored
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module imem_bus import fetch_pkg::*; #(
   parameter int IMEM_AW     = 10,
   parameter int WAIT_CYCLES = 2
) (
   input  logic      clk,
   input  logic      rst,

   input  ibus_req_t ibus_req_i,
   output ibus_rsp_t ibus_rsp_o,

   // preload port
   input  logic      load_we_i,
   input  addr_t     load_addr_i,
   input  insn_t     load_dat_i
);

   localparam int CNT_W = (WAIT_CYCLES > 1) ? $clog2(WAIT_CYCLES) : 1;

   typedef logic [IMEM_AW-1:0] word_idx_t;

   insn_t            mem [2**IMEM_AW];

   logic             busy;
   logic [CNT_W-1:0] wait_cnt;
   logic             rsp_due;
   logic             sample;

   // latched request
   word_idx_t        rd_idx;
   logic             rd_ok;

   word_idx_t        load_idx;
   logic             load_ok;

   assign sample = !busy & ibus_req_i.req;

   // byte address to word index, upper bits must be clear
   assign load_idx = load_addr_i[IMEM_AW+1:2];
   assign load_ok  = (load_addr_i[$bits(addr_t)-1:IMEM_AW+2] == '0);

   always_ff @(posedge clk) begin
      if (load_we_i & load_ok)
         mem[load_idx] <= load_dat_i;
   end

   // wait-state counter, last wait cycle is the response cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         busy     <= 1'b0;
         wait_cnt <= '0;
      end else if (sample) begin
         busy     <= 1'b1;
         wait_cnt <= CNT_W'(WAIT_CYCLES - 1);
      end else if (rsp_due) begin
         busy     <= 1'b0;
      end else if (busy) begin
         wait_cnt <= wait_cnt - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (sample) begin
         rd_idx <= ibus_req_i.addr[IMEM_AW+1:2];
         rd_ok  <= (ibus_req_i.addr[$bits(addr_t)-1:IMEM_AW+2] == '0);
      end
   end

   assign rsp_due = busy & (wait_cnt == '0);

   assign ibus_rsp_o.ack = rsp_due & rd_ok;
   assign ibus_rsp_o.err = rsp_due & !rd_ok;
   // only meaningful with ack
   assign ibus_rsp_o.dat = mem[rd_idx];

endmodule

//--- src/branch_predecode.sv
// ----------------------------------------------------------------------
// jump predecode at the decode boundary
// branch_occur_o rises in the cycle the jump is consumed and holds
// until the delay-slot word comes back with branch_taken set
// a jump placed in a delay slot is ignored
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module branch_predecode import fetch_pkg::*; (
   input  logic        clk,
   input  logic        rst,

   input  decode_bus_t decode_i,
   input  logic        fetch_valid_i,
   input  logic        padv_i,

   output logic        branch_occur_o,
   output addr_t       branch_dest_o
);

   opcode_t                opcode;
   logic [JUMP_OFF_W-1:0]  offset;
   addr_t                  jump_dest;
   logic                   jump_seen;

   logic                   occur_q;
   addr_t                  dest_q;

   assign opcode = decode_i.insn[$bits(insn_t)-1 -: $bits(opcode_t)];
   assign offset = decode_i.insn[JUMP_OFF_W-1:0];

   // pc + sign-extended word offset * 4
   assign jump_dest = decode_i.pc +
      {{($bits(addr_t)-JUMP_OFF_W-2){offset[JUMP_OFF_W-1]}}, offset, 2'b00};

   // consumed, error-free jump that is not itself a delay slot
   assign jump_seen = fetch_valid_i & padv_i & (opcode == OPC_JUMP) &
                      !decode_i.ibus_err & !decode_i.branch_taken;

   always_ff @(posedge clk) begin
      if (rst)
         occur_q <= 1'b0;
      else if (jump_seen)
         occur_q <= 1'b1;
      else if (decode_i.branch_taken)
         occur_q <= 1'b0;
   end

   always_ff @(posedge clk) begin
      if (jump_seen)
         dest_q <= jump_dest;
   end

   // pass the jump through in its own cycle so a delay slot arriving
   // at the same edge already sees it
   assign branch_occur_o = jump_seen | occur_q;
   assign branch_dest_o  = jump_seen ? jump_dest : dest_q;

endmodule

//--- src/fetch_top.sv
// ----------------------------------------------------------------------
// fetch subsystem top: fetch stage, instruction memory, jump predecode
// load port is for preloading only, while in reset or before the
// first padv_i; WAIT_CYCLES must be at least one
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module fetch_top import fetch_pkg::*; #(
   parameter addr_t RESET_PC    = 32'h0000_0100,
   parameter int    IMEM_AW     = 10,
   parameter int    WAIT_CYCLES = 2
) (
   input  logic        clk,
   input  logic        rst,

   // pipeline control
   input  logic        padv_i,
   input  logic        pipeline_flush_i,

   // debug restart
   input  logic        du_restart_i,
   input  addr_t       du_restart_pc_i,

   // memory preload
   input  logic        load_we_i,
   input  addr_t       load_addr_i,
   input  insn_t       load_dat_i,

   // toward decode
   output decode_bus_t decode_o,
   output logic        fetch_valid_o
);

   ibus_req_t ibus_req;
   ibus_rsp_t ibus_rsp;

   // jump request back into the address stage
   logic      branch_occur;
   addr_t     branch_dest;

   fetch_unit #(
      .RESET_PC         (RESET_PC)
   ) u_fetch (
      .clk              (clk),
      .rst              (rst),
      .padv_i           (padv_i),
      .pipeline_flush_i (pipeline_flush_i),
      .du_restart_i     (du_restart_i),
      .du_restart_pc_i  (du_restart_pc_i),
      .branch_occur_i   (branch_occur),
      .branch_dest_i    (branch_dest),
      .ibus_rsp_i       (ibus_rsp),
      .ibus_req_o       (ibus_req),
      .decode_o         (decode_o),
      .fetch_valid_o    (fetch_valid_o)
   );

   imem_bus #(
      .IMEM_AW          (IMEM_AW),
      .WAIT_CYCLES      (WAIT_CYCLES)
   ) u_imem (
      .clk              (clk),
      .rst              (rst),
      .ibus_req_i       (ibus_req),
      .ibus_rsp_o       (ibus_rsp),
      .load_we_i        (load_we_i),
      .load_addr_i      (load_addr_i),
      .load_dat_i       (load_dat_i)
   );

   // watches the same decode word that leaves the subsystem
   branch_predecode u_predecode (
      .clk              (clk),
      .rst              (rst),
      .decode_i         (decode_o),
      .fetch_valid_i    (fetch_valid_o),
      .padv_i           (padv_i),
      .branch_occur_o   (branch_occur),
      .branch_dest_o    (branch_dest)
   );

endmodule

//--- tests/fetch_checks.svh
// ----------------------------------------------------------------------
// compare tasks for the fetch testbench, included inside the tb module
// relies on the fetch_pkg import of the including module
// counts passing compares and mismatches for the final summary
// ----------------------------------------------------------------------
`ifndef FETCH_CHECKS_SVH
`define FETCH_CHECKS_SVH

// running totals over the whole run
int pass_cnt     = 0;
int mismatch_cnt = 0;

// program counters and byte addresses
task automatic compare_addr(input string what, input addr_t got, input addr_t exp);
   if (got === exp) begin
      pass_cnt++;
   end else begin
      mismatch_cnt++;
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
   end
endtask

// instruction words
task automatic test_insn(input string what, input insn_t got, input insn_t exp);
   if (got === exp) begin
      pass_cnt++;
   end else begin
      mismatch_cnt++;
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
   end
endtask

// single-bit flags, valid, error and taken
task automatic expect_flag(input string what, input logic got, input logic exp);
   if (got === exp) begin
      pass_cnt++;
   end else begin
      mismatch_cnt++;
      $display("MISMATCH at %0t ns: %s got %b expected %b", $time, what, got, exp);
   end
endtask

`endif

//--- tests/fetch_tb.sv
// ----------------------------------------------------------------------
// testbench for fetch_top, 64-word memory with two wait states
// program sits at 0x40..0x80 and is preloaded while in reset
// each table row restarts from reset and checks every consumed slot
// events hold padv_i low, then flush and/or restart the fetch stage
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module fetch_tb import fetch_pkg::*; ();

   localparam addr_t RESET_PC     = 32'h0000_0040;
   localparam int    IMEM_AW      = 6;
   localparam int    WAIT_CYCLES  = 2;
   localparam int    RESET_CYCLES = 4;
   localparam int    NUM_CASES    = 6;
   // bytes covered by the memory, anything above answers with err
   localparam addr_t MEM_BYTES    = 32'd1 << (IMEM_AW + 2);
   localparam addr_t PROG_FIRST   = 32'h0000_0040;
   localparam addr_t PROG_LAST    = 32'h0000_0080;

   localparam logic [1:0] EV_NONE    = 2'd0;
   localparam logic [1:0] EV_RESTART = 2'd1;
   // flush pulse, then restart on the next cycle
   localparam logic [1:0] EV_FLUSH   = 2'd2;

   typedef struct packed {
      logic       rand_padv;
      logic [1:0] ev;
      logic [7:0] ev_slot;
      addr_t      ev_pc;
      logic [7:0] n_slots;
   } case_t;

   logic        clk;
   logic        rst;
   logic        padv_i;
   logic        pipeline_flush_i;
   logic        du_restart_i;
   addr_t       du_restart_pc_i;
   logic        load_we_i;
   addr_t       load_addr_i;
   insn_t       load_dat_i;
   decode_bus_t decode_o;
   logic        fetch_valid_o;

   // expected stream of the current case
   addr_t       exp_pc    [64];
   insn_t       exp_insn  [64];
   logic        exp_err   [64];
   logic        exp_taken [64];

   case_t       cases [NUM_CASES];
   int          cycle_cnt     = 0;
   int          timeout_limit = 0;
   int          failed_tests  = 0;
   int          total_slots;
   int          c;
   int unsigned seed;

   `include "fetch_checks.svh"

   fetch_top #(
      .RESET_PC         (RESET_PC),
      .IMEM_AW          (IMEM_AW),
      .WAIT_CYCLES      (WAIT_CYCLES)
   ) dut (
      .clk              (clk),
      .rst              (rst),
      .padv_i           (padv_i),
      .pipeline_flush_i (pipeline_flush_i),
      .du_restart_i     (du_restart_i),
      .du_restart_pc_i  (du_restart_pc_i),
      .load_we_i        (load_we_i),
      .load_addr_i      (load_addr_i),
      .load_dat_i       (load_dat_i),
      .decode_o         (decode_o),
      .fetch_valid_o    (fetch_valid_o)
   );

   always #5 clk = ~clk;

   // watchdog over the whole run
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (timeout_limit != 0 && cycle_cnt >= timeout_limit) begin
         $display("timeout: expected slots not delivered after %0d cycles", cycle_cnt);
         $display("Verification failed");
         $finish;
      end
   end

   // program image: two jumps, everything else plain words
   // 0x58 jumps +6 words to 0x70, 0x7c jumps past memory to 0x200
   function automatic insn_t prog_word(input addr_t a);
      case (a)
         32'h0000_0058: prog_word = {OPC_JUMP, 26'd6};
         32'h0000_007c: prog_word = {OPC_JUMP, 26'h61};
         default:       prog_word = {6'h11, a[25:0] ^ {20'h0, a[31:26]}};
      endcase
   endfunction

   function automatic case_t make_case(input logic rand_padv, input logic [1:0] ev,
                                       input int ev_slot, input addr_t ev_pc,
                                       input int n_slots);
      case_t cs;
      cs.rand_padv = rand_padv;
      cs.ev        = ev;
      cs.ev_slot   = ev_slot[7:0];
      cs.ev_pc     = ev_pc;
      cs.n_slots   = n_slots[7:0];
      return cs;
   endfunction

   // reference walk of the program, one entry per consumed slot
   task automatic build_stream(input case_t cs);
      addr_t pc;
      addr_t dest;
      logic  pend;
      insn_t w;
      int    off;
      pc   = RESET_PC;
      dest = '0;
      pend = 1'b0;
      for (int i = 0; i < cs.n_slots; i++) begin
         if (cs.ev != EV_NONE && i == cs.ev_slot) begin
            pc   = cs.ev_pc;
            pend = 1'b0;
         end
         w            = prog_word(pc);
         exp_pc[i]    = pc;
         exp_err[i]   = (pc >= MEM_BYTES);
         exp_insn[i]  = exp_err[i] ? NOP_INSN : w;
         // delay slot carries the taken mark
         exp_taken[i] = pend;
         if (pend) begin
            pc   = dest;
            pend = 1'b0;
         end else if (!exp_err[i] && w[31:26] == OPC_JUMP) begin
            // signed word offset, scaled to bytes
            off  = $signed(w[25:0]);
            dest = pc + addr_t'(off * 4);
            pend = 1'b1;
            pc   = pc + 32'd4;
         end else begin
            pc = pc + 32'd4;
         end
      end
   endtask

   // words go in while rst is high, before any advance
   task automatic load_program();
      addr_t a;
      for (a = PROG_FIRST; a <= PROG_LAST; a = a + 32'd4) begin
         @(negedge clk);
         load_we_i   = 1'b1;
         load_addr_i = a;
         load_dat_i  = prog_word(a);
      end
      @(negedge clk);
      load_we_i = 1'b0;
   endtask

   task automatic apply_reset();
      rst              = 1'b1;
      padv_i           = 1'b0;
      pipeline_flush_i = 1'b0;
      du_restart_i     = 1'b0;
      repeat (RESET_CYCLES) @(negedge clk);
      rst = 1'b0;
      expect_flag("fetch_valid_o", fetch_valid_o, 1'b0);
      expect_flag("decode_o.ibus_err", decode_o.ibus_err, 1'b0);
      expect_flag("decode_o.branch_taken", decode_o.branch_taken, 1'b0);
   endtask

   // stall, then optional flush, then restart at ev_pc
   task automatic fire_event(input case_t cs, input int idx);
      padv_i = 1'b0;
      repeat (WAIT_CYCLES + 2) @(negedge clk);
      // error flag must still match the last consumed slot
      if (idx > 0)
         expect_flag("decode_o.ibus_err", decode_o.ibus_err, exp_err[idx-1]);
      if (cs.ev == EV_FLUSH) begin
         pipeline_flush_i = 1'b1;
         @(negedge clk);
         pipeline_flush_i = 1'b0;
         expect_flag("fetch_valid_o", fetch_valid_o, 1'b0);
      end
      du_restart_i    = 1'b1;
      du_restart_pc_i = cs.ev_pc;
      @(negedge clk);
      du_restart_i = 1'b0;
      expect_flag("fetch_valid_o", fetch_valid_o, 1'b0);
      expect_flag("decode_o.ibus_err", decode_o.ibus_err, 1'b0);
   endtask

   task automatic run_case(input int num, input case_t cs);
      int   idx;
      int   errs_before;
      logic ev_pending;
      build_stream(cs);
      errs_before = mismatch_cnt;
      apply_reset();
      idx        = 0;
      ev_pending = (cs.ev != EV_NONE);
      while (idx < cs.n_slots) begin
         @(negedge clk);
         if (ev_pending && idx == cs.ev_slot) begin
            fire_event(cs, idx);
            ev_pending = 1'b0;
         end else begin
            padv_i = cs.rand_padv ? (($urandom % 4) != 0) : 1'b1;
            // slot is consumed at the coming rising edge
            if (fetch_valid_o && padv_i) begin
               compare_addr("decode_o.pc", decode_o.pc, exp_pc[idx]);
               test_insn("decode_o.insn", decode_o.insn, exp_insn[idx]);
               expect_flag("decode_o.ibus_err", decode_o.ibus_err, exp_err[idx]);
               expect_flag("decode_o.branch_taken", decode_o.branch_taken,
                           exp_taken[idx]);
               idx++;
            end
         end
      end
      @(negedge clk);
      padv_i = 1'b0;
      if (mismatch_cnt != errs_before)
         failed_tests++;
      $display("test %0d: %0d slots, padv %s, event %0d, %0d mismatches, %s",
               num, cs.n_slots, cs.rand_padv ? "random" : "steady", cs.ev,
               mismatch_cnt - errs_before,
               (mismatch_cnt == errs_before) ? "ok" : "FAILED");
   endtask

   initial begin
      clk              = 1'b0;
      rst              = 1'b1;
      padv_i           = 1'b0;
      pipeline_flush_i = 1'b0;
      du_restart_i     = 1'b0;
      du_restart_pc_i  = '0;
      load_we_i        = 1'b0;
      load_addr_i      = '0;
      load_dat_i       = '0;
      seed             = 32'hd2e71485;
      void'($urandom(seed));

      // straight line, jump, stalled jump, jump out of memory,
      // restart after the error, flush plus restart mid-stream
      cases[0] = make_case(1'b0, EV_NONE,    0,  32'h0,  6);
      cases[1] = make_case(1'b0, EV_NONE,    0,  32'h0,  11);
      cases[2] = make_case(1'b1, EV_NONE,    0,  32'h0,  11);
      cases[3] = make_case(1'b0, EV_NONE,    0,  32'h0,  14);
      cases[4] = make_case(1'b1, EV_RESTART, 14, 32'h48, 17);
      cases[5] = make_case(1'b0, EV_FLUSH,   3,  32'h70, 6);

      total_slots = 0;
      for (c = 0; c < NUM_CASES; c++)
         total_slots += cases[c].n_slots;
      timeout_limit = total_slots * (WAIT_CYCLES + 2) * 4 +
                      NUM_CASES * (RESET_CYCLES + 2 * (WAIT_CYCLES + 2) + 4) + 32;

      load_program();
      for (c = 0; c < NUM_CASES; c++)
         run_case(c, cases[c]);

      $display("summary: %0d checks passed, %0d mismatches, %0d of %0d tests failed",
               pass_cnt, mismatch_cnt, failed_tests, NUM_CASES);
      if (mismatch_cnt == 0 && failed_tests == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

//--- fetch_sub.f
+incdir+tests
common/fetch_pkg.sv
fetch/fetch_unit.sv
src/imem_bus.sv
src/branch_predecode.sv
src/fetch_top.sv
tests/fetch_tb.sv
